//--- src/kotku_defines.svh
`ifndef KOTKU_DEFINES_SVH
`define KOTKU_DEFINES_SVH

// bus geometry
`define KOTKU_DATA_W 16
`define KOTKU_WADR_W 19
`define KOTKU_IRQ_N  8

// vector for irq line 0, line n answers base + n
`define KOTKU_INT_VECTOR_BASE 16'h0008

// unmapped reads float high
`define KOTKU_DEFAULT_DATA 16'hffff

// decode windows over the tagged address {io tag, word address}
// a cycle hits when (addr & mask) == match

// rom, mem 0xf0000 - 0xfffff
`define KOTKU_ROM_HI_MATCH 20'h7_8000
`define KOTKU_ROM_HI_MASK  20'hf_8000

// rom shadow, mem 0xc0000 - 0xcffff
`define KOTKU_ROM_LO_MATCH 20'h6_0000
`define KOTKU_ROM_LO_MASK  20'hf_8000

// com1, io 0x3f8 - 0x3ff
`define KOTKU_UART_MATCH 20'h8_01fc
`define KOTKU_UART_MASK  20'h8_7ffc

// keyboard data and status, io 0x60 and 0x64
// word bit 1 is ignored so both ports land here
`define KOTKU_KEYB_MATCH 20'h8_0030
`define KOTKU_KEYB_MASK  20'h8_7ffd

// ram takes whatever memory is left
`define KOTKU_RAM_MATCH 20'h0_0000
`define KOTKU_RAM_MASK  20'h8_0000

`endif

//--- src/kotku_pkg.sv
`include "kotku_defines.svh"

package kotku_pkg;

  // one bus data word and its byte lanes
  typedef logic [`KOTKU_DATA_W-1:0]   wb_data_t;
  typedef logic [`KOTKU_DATA_W/8-1:0] wb_sel_t;

  // word address as seen by the slaves
  typedef logic [`KOTKU_WADR_W-1:0] wb_wadr_t;

  // tagged cpu address
  // the same 20 bits read as a memory word address or an io port
  typedef union packed {
    struct packed {
      logic     is_io;
      wb_wadr_t wadr;
    } mem;
    struct packed {
      logic        is_io;
      logic [2:0]  rsvd;
      logic [15:0] port;
    } io;
  } bus_addr_u;

  // interrupt lines and the number of one line
  typedef logic [`KOTKU_IRQ_N-1:0]         irq_vec_t;
  typedef logic [$clog2(`KOTKU_IRQ_N)-1:0] iid_t;

endpackage

//--- src/wb_slave_switch.sv
`timescale 1ns/10ps

`include "kotku_defines.svh"

module wb_slave_switch (
  // master side
  input  kotku_pkg::bus_addr_u adr_i,
  input  kotku_pkg::wb_data_t  dat_i,
  input  kotku_pkg::wb_sel_t   sel_i,
  input                        we_i,
  input                        cyc_i,
  input                        stb_i,
  output kotku_pkg::wb_data_t  dat_o,
  output logic                 ack_o,

  // shared slave signals
  output kotku_pkg::wb_wadr_t  s_adr_o,
  output kotku_pkg::wb_data_t  s_dat_o,
  output kotku_pkg::wb_sel_t   s_sel_o,
  output logic                 s_we_o,

  // bios rom
  output logic                 rom_stb_o,
  input                        rom_ack_i,
  input  kotku_pkg::wb_data_t  rom_dat_i,

  // main memory
  output logic                 ram_stb_o,
  input                        ram_ack_i,
  input  kotku_pkg::wb_data_t  ram_dat_i,

  // com1
  output logic                 uart_stb_o,
  input                        uart_ack_i,
  input  kotku_pkg::wb_data_t  uart_dat_i,

  // keyboard controller
  output logic                 keyb_stb_o,
  input                        keyb_ack_i,
  input  kotku_pkg::wb_data_t  keyb_dat_i
);

  logic [`KOTKU_WADR_W:0] mem_key;
  logic [`KOTKU_WADR_W:0] io_key;

  logic hit_rom;
  logic hit_uart;
  logic hit_keyb;
  logic hit_ram;

  logic sel_rom;
  logic sel_uart;
  logic sel_keyb;
  logic sel_ram;

  logic cyc_stb;
  logic ack_sel;

  function automatic logic win_hit(
    input logic [`KOTKU_WADR_W:0] key,
    input logic [`KOTKU_WADR_W:0] match,
    input logic [`KOTKU_WADR_W:0] mask
  );
    return (key & mask) == match;
  endfunction

  // memory view keeps the full word address
  assign mem_key = {adr_i.mem.is_io, adr_i.mem.wadr};
  // io view, bits above the port never take part in a match
  assign io_key  = {adr_i.io.is_io, 3'b000, adr_i.io.port};

  assign hit_rom  = win_hit(mem_key, `KOTKU_ROM_HI_MATCH, `KOTKU_ROM_HI_MASK) |
                    win_hit(mem_key, `KOTKU_ROM_LO_MATCH, `KOTKU_ROM_LO_MASK);
  assign hit_uart = win_hit(io_key, `KOTKU_UART_MATCH, `KOTKU_UART_MASK);
  assign hit_keyb = win_hit(io_key, `KOTKU_KEYB_MATCH, `KOTKU_KEYB_MASK);
  assign hit_ram  = win_hit(mem_key, `KOTKU_RAM_MATCH, `KOTKU_RAM_MASK);

  // rom, uart, keyboard, ram in that order
  assign sel_rom  = hit_rom;
  assign sel_uart = !hit_rom && hit_uart;
  assign sel_keyb = !hit_rom && !hit_uart && hit_keyb;
  assign sel_ram  = !hit_rom && !hit_uart && !hit_keyb && hit_ram;

  assign cyc_stb = cyc_i && stb_i;

  assign rom_stb_o  = cyc_stb && sel_rom;
  assign uart_stb_o = cyc_stb && sel_uart;
  assign keyb_stb_o = cyc_stb && sel_keyb;
  assign ram_stb_o  = cyc_stb && sel_ram;

  // address, data and lanes go to every slave unchanged
  assign s_adr_o = adr_i.mem.wadr;
  assign s_dat_o = dat_i;
  assign s_sel_o = sel_i;
  assign s_we_o  = we_i;

  // reply mux, unmatched cycles answer themselves
  always_comb begin
    if (sel_rom) begin
      ack_sel = rom_ack_i;
      dat_o   = rom_dat_i;
    end else if (sel_uart) begin
      ack_sel = uart_ack_i;
      dat_o   = uart_dat_i;
    end else if (sel_keyb) begin
      ack_sel = keyb_ack_i;
      dat_o   = keyb_dat_i;
    end else if (sel_ram) begin
      ack_sel = ram_ack_i;
      dat_o   = ram_dat_i;
    end else begin
      ack_sel = 1'b1;
      dat_o   = `KOTKU_DEFAULT_DATA;
    end
  end

  assign ack_o = cyc_stb && ack_sel;

endmodule

//--- src/simple_pic.sv
`timescale 1ns/10ps

`include "kotku_defines.svh"

module simple_pic (
  input                       clk,
  input                       rst,

  // raw interrupt lines
  input  kotku_pkg::irq_vec_t irq_i,
  // clears the line reported on iid_o
  input                       ack_i,

  output logic                intr_o,
  output kotku_pkg::iid_t     iid_o
);

  kotku_pkg::irq_vec_t irq_q;
  kotku_pkg::irq_vec_t pending;
  kotku_pkg::irq_vec_t rising;
  kotku_pkg::irq_vec_t clr;

  // line history follows the pins even in reset
  // so a level already high at release is not an edge
  always_ff @(posedge clk) begin
    irq_q <= irq_i;
  end

  assign rising = irq_i & ~irq_q;

  // bit of the line being acknowledged
  assign clr = ack_i ? kotku_pkg::irq_vec_t'(1) << iid_o : '0;

  // a fresh edge beats a clear on the same line
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~clr) | rising;
    end
  end

  assign intr_o = |pending;

  // lowest numbered pending line wins
  always_comb begin
    iid_o = '0;
    for (int i = `KOTKU_IRQ_N - 1; i >= 0; i--) begin
      if (pending[i]) begin
        iid_o = kotku_pkg::iid_t'(i);
      end
    end
  end

endmodule

//--- src/cpu_bus_port.sv
`timescale 1ns/10ps

`include "kotku_defines.svh"

module cpu_bus_port (
  input                       clk,
  input                       rst,

  // cpu strobes
  input                       m_cyc_i,
  input                       m_stb_i,
  input                       m_inta_i,

  // interrupt controller
  input                       intr_i,
  input  kotku_pkg::iid_t     iid_i,
  output logic                pic_ack_o,

  // switch
  output logic                sw_stb_o,
  input                       sw_ack_i,
  input  kotku_pkg::wb_data_t sw_dat_i,

  // reply to the cpu
  output logic                m_ack_o,
  output kotku_pkg::wb_data_t m_dat_o,
  output logic                m_intr_o
);

  logic                inta_cyc;
  logic                inta_done;
  kotku_pkg::wb_data_t vector;

  assign inta_cyc = m_cyc_i && m_stb_i && m_inta_i;

  // acknowledge reads never reach a slave
  assign sw_stb_o = m_stb_i && !m_inta_i;

  // vector of the line currently reported
  assign vector = `KOTKU_INT_VECTOR_BASE + kotku_pkg::wb_data_t'(iid_i);

  // set once the first ack of an inta cycle is taken
  // holds while the cpu keeps the strobe up on the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      inta_done <= 1'b0;
    end else begin
      inta_done <= inta_cyc;
    end
  end

  // one clear per acknowledge cycle
  assign pic_ack_o = inta_cyc && !inta_done;

  // inta answered here in the same cycle, all else from the switch
  always_comb begin
    if (m_inta_i) begin
      m_ack_o = inta_cyc;
      m_dat_o = vector;
    end else begin
      m_ack_o = sw_ack_i;
      m_dat_o = sw_dat_i;
    end
  end

  assign m_intr_o = intr_i;

endmodule

//--- src/kotku_bus.sv
`timescale 1ns/10ps

module kotku_bus (
  input                        clk,
  input                        rst,

  // cpu master
  input  kotku_pkg::bus_addr_u m_adr_i,
  input  kotku_pkg::wb_data_t  m_dat_i,
  output kotku_pkg::wb_data_t  m_dat_o,
  input  kotku_pkg::wb_sel_t   m_sel_i,
  input                        m_we_i,
  input                        m_cyc_i,
  input                        m_stb_i,
  output logic                 m_ack_o,
  input                        m_inta_i,
  output logic                 m_intr_o,

  // interrupt sources
  input  kotku_pkg::irq_vec_t  irq_i,

  // shared slave bus
  output kotku_pkg::wb_wadr_t  s_adr_o,
  output kotku_pkg::wb_data_t  s_dat_o,
  output kotku_pkg::wb_sel_t   s_sel_o,
  output logic                 s_we_o,

  // per slave strobe and reply
  output logic                 rom_stb_o,
  output logic                 ram_stb_o,
  output logic                 uart_stb_o,
  output logic                 keyb_stb_o,
  input                        rom_ack_i,
  input                        ram_ack_i,
  input                        uart_ack_i,
  input                        keyb_ack_i,
  input  kotku_pkg::wb_data_t  rom_dat_i,
  input  kotku_pkg::wb_data_t  ram_dat_i,
  input  kotku_pkg::wb_data_t  uart_dat_i,
  input  kotku_pkg::wb_data_t  keyb_dat_i
);

  // port to switch
  logic                sw_stb;
  logic                sw_ack;
  kotku_pkg::wb_data_t sw_dat;

  // port to pic
  logic                pic_intr;
  logic                pic_ack;
  kotku_pkg::iid_t     pic_iid;

  wb_slave_switch u_switch (
    .adr_i      (m_adr_i),
    .dat_i      (m_dat_i),
    .sel_i      (m_sel_i),
    .we_i       (m_we_i),
    .cyc_i      (m_cyc_i),
    .stb_i      (sw_stb),
    .dat_o      (sw_dat),
    .ack_o      (sw_ack),
    .s_adr_o    (s_adr_o),
    .s_dat_o    (s_dat_o),
    .s_sel_o    (s_sel_o),
    .s_we_o     (s_we_o),
    .rom_stb_o  (rom_stb_o),
    .rom_ack_i  (rom_ack_i),
    .rom_dat_i  (rom_dat_i),
    .ram_stb_o  (ram_stb_o),
    .ram_ack_i  (ram_ack_i),
    .ram_dat_i  (ram_dat_i),
    .uart_stb_o (uart_stb_o),
    .uart_ack_i (uart_ack_i),
    .uart_dat_i (uart_dat_i),
    .keyb_stb_o (keyb_stb_o),
    .keyb_ack_i (keyb_ack_i),
    .keyb_dat_i (keyb_dat_i)
  );

  simple_pic u_pic (
    .clk    (clk),
    .rst    (rst),
    .irq_i  (irq_i),
    .ack_i  (pic_ack),
    .intr_o (pic_intr),
    .iid_o  (pic_iid)
  );

  cpu_bus_port u_port (
    .clk       (clk),
    .rst       (rst),
    .m_cyc_i   (m_cyc_i),
    .m_stb_i   (m_stb_i),
    .m_inta_i  (m_inta_i),
    .intr_i    (pic_intr),
    .iid_i     (pic_iid),
    .pic_ack_o (pic_ack),
    .sw_stb_o  (sw_stb),
    .sw_ack_i  (sw_ack),
    .sw_dat_i  (sw_dat),
    .m_ack_o   (m_ack_o),
    .m_dat_o   (m_dat_o),
    .m_intr_o  (m_intr_o)
  );

endmodule

//--- tb/kotku_bus_sva.sv
`timescale 1ns/10ps

module kotku_bus_sva (
  input logic clk,
  input logic rst,
  input logic m_cyc_i,
  input logic m_stb_i,
  input logic m_inta_i,
  input logic m_ack_o,
  input logic m_intr_o,
  input logic rom_stb_o,
  input logic ram_stb_o,
  input logic uart_stb_o,
  input logic keyb_stb_o
);

  logic [3:0] strobes;

  assign strobes = {keyb_stb_o, uart_stb_o, ram_stb_o, rom_stb_o};

  one_slave: assert property (@(posedge clk) disable iff (rst) $onehot0(strobes))
    else $error("more than one slave strobe is high");

  // vector reads are answered by the port itself
  no_slave_in_inta: assert property (@(posedge clk) disable iff (rst) m_inta_i |-> strobes == 4'b0)
    else $error("slave strobe raised during an interrupt acknowledge");

  ack_in_cycle: assert property (@(posedge clk) disable iff (rst) m_ack_o |-> m_cyc_i && m_stb_i)
    else $error("m_ack_o without an active cycle");

  intr_after_rst: assert property (@(posedge clk) rst |=> !m_intr_o)
    else $error("m_intr_o high right after reset");

endmodule

bind kotku_bus kotku_bus_sva u_sva (.*);

//--- tb/tb_kotku_bus.sv
`timescale 1ns/10ps

module tb_kotku_bus;

  localparam int RST_CYCLES = 8;

  // one-hot slave codes in {keyb, uart, ram, rom} order
  localparam logic [3:0] SL_NONE = 4'b0000;
  localparam logic [3:0] SL_ROM  = 4'b0001;
  localparam logic [3:0] SL_RAM  = 4'b0010;
  localparam logic [3:0] SL_UART = 4'b0100;
  localparam logic [3:0] SL_KEYB = 4'b1000;

  // slave models answer tag ^ low word address
  localparam logic [15:0] ROM_TAG  = 16'hc000;
  localparam logic [15:0] RAM_TAG  = 16'h5a00;
  localparam logic [15:0] UART_TAG = 16'h3c00;
  localparam logic [15:0] KEYB_TAG = 16'h0f00;

  typedef enum logic [1:0] {OP_RD, OP_WR, OP_IRQ, OP_INTA} op_t;

  typedef struct packed {
    op_t         op;
    logic        io;
    logic [19:0] addr;
    logic [15:0] wdat;
    logic [1:0]  sel;
    logic [7:0]  irq;
    logic [3:0]  slave;
    logic [15:0] rdat;
    logic        intr;
  } row_t;

  logic                 clk;
  logic                 rst;
  kotku_pkg::bus_addr_u m_adr_i;
  kotku_pkg::wb_data_t  m_dat_i;
  kotku_pkg::wb_data_t  m_dat_o;
  kotku_pkg::wb_sel_t   m_sel_i;
  logic                 m_we_i;
  logic                 m_cyc_i;
  logic                 m_stb_i;
  logic                 m_ack_o;
  logic                 m_inta_i;
  logic                 m_intr_o;
  kotku_pkg::irq_vec_t  irq_i;
  kotku_pkg::wb_wadr_t  s_adr_o;
  kotku_pkg::wb_data_t  s_dat_o;
  kotku_pkg::wb_sel_t   s_sel_o;
  logic                 s_we_o;
  logic                 rom_stb_o;
  logic                 ram_stb_o;
  logic                 uart_stb_o;
  logic                 keyb_stb_o;
  logic                 rom_ack_i;
  logic                 ram_ack_i;
  logic                 uart_ack_i;
  logic                 keyb_ack_i;
  kotku_pkg::wb_data_t  rom_dat_i;
  kotku_pkg::wb_data_t  ram_dat_i;
  kotku_pkg::wb_data_t  uart_dat_i;
  kotku_pkg::wb_data_t  keyb_dat_i;

  logic [3:0]          strobes;
  int                  ack_delay;
  int                  cycle_cnt;
  int                  cycle_limit;
  row_t                rows[$];
  // lines the interrupt controller should hold pending
  kotku_pkg::irq_vec_t pend_model;

  kotku_bus u_kotku_bus (.*);

  assign strobes = {keyb_stb_o, uart_stb_o, ram_stb_o, rom_stb_o};

  // only one slave is strobed at a time so they share one wait counter
  assign rom_ack_i  = rom_stb_o && (ack_delay == 0);
  assign ram_ack_i  = ram_stb_o && (ack_delay == 0);
  assign uart_ack_i = uart_stb_o && (ack_delay == 0);
  assign keyb_ack_i = keyb_stb_o && (ack_delay == 0);
  assign rom_dat_i  = ROM_TAG ^ s_adr_o[15:0];
  assign ram_dat_i  = RAM_TAG ^ s_adr_o[15:0];
  assign uart_dat_i = UART_TAG ^ s_adr_o[15:0];
  assign keyb_dat_i = KEYB_TAG ^ s_adr_o[15:0];

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Done: errors found");
      $fatal(1, "run stopped by cycle limit");
    end
  end

  task automatic report_mismatch(input string msg);
    $display("Mismatch at %0t: %s", $time, msg);
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(input kotku_pkg::wb_data_t got, input kotku_pkg::wb_data_t exp,
                            input string what);
    if (got !== exp) report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  task automatic check_iid(input kotku_pkg::iid_t got, input kotku_pkg::iid_t exp);
    if (got !== exp) report_mismatch($sformatf("vector line: got %0d, expected %0d", got, exp));
  endtask

  task automatic check_adr(input kotku_pkg::wb_wadr_t got, input kotku_pkg::wb_wadr_t exp);
    if (got !== exp) report_mismatch($sformatf("s_adr_o: got %h, expected %h", got, exp));
  endtask

  task automatic check_sel(input kotku_pkg::wb_sel_t got, input kotku_pkg::wb_sel_t exp);
    if (got !== exp) report_mismatch($sformatf("s_sel_o: got %b, expected %b", got, exp));
  endtask

  task automatic check_strobe(input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) report_mismatch($sformatf("slave strobes: got %b, expected %b", got, exp));
  endtask

  task automatic check_intr(input logic got, input logic exp, input string what);
    if (got !== exp) report_mismatch($sformatf("%s: m_intr_o %b, expected %b", what, got, exp));
  endtask

  // lowest numbered line set in a pending mask
  function automatic kotku_pkg::iid_t lowest_line(input kotku_pkg::irq_vec_t lines);
    int n;
    n = 0;
    while (n < $bits(kotku_pkg::irq_vec_t) - 1 && !lines[n]) begin
      n++;
    end
    return kotku_pkg::iid_t'(n);
  endfunction

  task automatic add_row(input op_t op, input logic io, input logic [19:0] addr,
                         input logic [15:0] wdat, input logic [1:0] sel, input logic [7:0] irq,
                         input logic [3:0] slave, input logic [15:0] rdat, input logic intr);
    rows.push_back('{op, io, addr, wdat, sel, irq, slave, rdat, intr});
  endtask

  // op, io, byte address, write data, selects, irq lines, slave, read data, intr
  task automatic build_table();
    add_row(OP_RD, 1'b0, 20'hf0000, 16'h0000, 2'b11, 8'h00, SL_ROM, 16'h4000, 1'b0);
    add_row(OP_RD, 1'b0, 20'hffffe, 16'h0000, 2'b11, 8'h00, SL_ROM, 16'h3fff, 1'b0);
    add_row(OP_RD, 1'b0, 20'hc0010, 16'h0000, 2'b11, 8'h00, SL_ROM, 16'hc008, 1'b0);
    add_row(OP_RD, 1'b0, 20'hcfffe, 16'h0000, 2'b11, 8'h00, SL_ROM, 16'hbfff, 1'b0);
    add_row(OP_RD, 1'b0, 20'hd0000, 16'h0000, 2'b11, 8'h00, SL_RAM, 16'hda00, 1'b0);
    add_row(OP_RD, 1'b0, 20'h00400, 16'h0000, 2'b11, 8'h00, SL_RAM, 16'h5800, 1'b0);
    add_row(OP_RD, 1'b0, 20'hbfffe, 16'h0000, 2'b11, 8'h00, SL_RAM, 16'ha5ff, 1'b0);
    add_row(OP_RD, 1'b1, 20'h003f8, 16'h0000, 2'b11, 8'h00, SL_UART, 16'h3dfc, 1'b0);
    add_row(OP_RD, 1'b1, 20'h003fe, 16'h0000, 2'b11, 8'h00, SL_UART, 16'h3dff, 1'b0);
    add_row(OP_RD, 1'b1, 20'h00060, 16'h0000, 2'b11, 8'h00, SL_KEYB, 16'h0f30, 1'b0);
    add_row(OP_RD, 1'b1, 20'h00064, 16'h0000, 2'b11, 8'h00, SL_KEYB, 16'h0f32, 1'b0);
    add_row(OP_RD, 1'b1, 20'h00062, 16'h0000, 2'b11, 8'h00, SL_NONE, 16'hffff, 1'b0);
    add_row(OP_RD, 1'b1, 20'h003f0, 16'h0000, 2'b11, 8'h00, SL_NONE, 16'hffff, 1'b0);
    add_row(OP_WR, 1'b0, 20'h12344, 16'hbeef, 2'b11, 8'h00, SL_RAM, 16'h0000, 1'b0);
    add_row(OP_WR, 1'b1, 20'h003f9, 16'h0055, 2'b10, 8'h00, SL_UART, 16'h0000, 1'b0);
    add_row(OP_WR, 1'b0, 20'hf8000, 16'h1234, 2'b01, 8'h00, SL_ROM, 16'h0000, 1'b0);
    // lines 4 and 1 then two vector reads
    add_row(OP_IRQ, 1'b0, 20'h00000, 16'h0000, 2'b00, 8'h12, SL_NONE, 16'h0000, 1'b1);
    add_row(OP_INTA, 1'b0, 20'h00000, 16'h0000, 2'b11, 8'h00, SL_NONE, 16'h0009, 1'b1);
    add_row(OP_INTA, 1'b0, 20'h00000, 16'h0000, 2'b11, 8'h00, SL_NONE, 16'h000c, 1'b0);
    // held level must not fire again
    add_row(OP_IRQ, 1'b0, 20'h00000, 16'h0000, 2'b00, 8'h12, SL_NONE, 16'h0000, 1'b0);
    add_row(OP_IRQ, 1'b0, 20'h00000, 16'h0000, 2'b00, 8'h00, SL_NONE, 16'h0000, 1'b0);
    add_row(OP_IRQ, 1'b0, 20'h00000, 16'h0000, 2'b00, 8'h02, SL_NONE, 16'h0000, 1'b1);
    add_row(OP_INTA, 1'b0, 20'h00000, 16'h0000, 2'b11, 8'h00, SL_NONE, 16'h0009, 1'b0);
    add_row(OP_RD, 1'b0, 20'h00400, 16'h0000, 2'b11, 8'h00, SL_RAM, 16'h5800, 1'b0);
  endtask

  // shared slave signals must follow the master while a slave is strobed
  task automatic check_slave_bus(input row_t r);
    check_adr(s_adr_o, r.addr[19:1]);
    check_data(s_dat_o, r.wdat, "s_dat_o");
    check_sel(s_sel_o, r.sel);
    if (s_we_o !== (r.op == OP_WR)) report_mismatch("s_we_o does not follow m_we_i");
  endtask

  // entered and left just after a rising edge
  task automatic run_row(input row_t r);
    int                  waited;
    kotku_pkg::wb_data_t rdat;
    kotku_pkg::iid_t     exp_line;
    if (r.op == OP_IRQ) begin
      pend_model = pend_model | (r.irq & ~irq_i);
      irq_i = r.irq;
      repeat (2) @(posedge clk);
      #1;
      check_intr(m_intr_o, r.intr, "after irq change");
    end else begin
      if (r.io) begin
        m_adr_i.io.is_io = 1'b1;
        m_adr_i.io.rsvd  = 3'b000;
        m_adr_i.io.port  = r.addr[16:1];
      end else begin
        m_adr_i.mem.is_io = 1'b0;
        m_adr_i.mem.wadr  = r.addr[19:1];
      end
      m_dat_i   = r.wdat;
      m_sel_i   = r.sel;
      m_we_i    = (r.op == OP_WR);
      m_inta_i  = (r.op == OP_INTA);
      m_cyc_i   = 1'b1;
      m_stb_i   = 1'b1;
      ack_delay = (r.op == OP_INTA) ? 0 : int'($urandom % 4);
      waited    = 0;
      @(negedge clk);
      while (!m_ack_o) begin
        check_strobe(strobes, r.slave);
        if (r.slave != SL_NONE) check_slave_bus(r);
        @(posedge clk);
        #1;
        if (ack_delay != 0) ack_delay--;
        waited++;
        @(negedge clk);
      end
      check_strobe(strobes, r.slave);
      if (r.slave != SL_NONE) check_slave_bus(r);
      rdat = m_dat_o;
      if (r.slave == SL_NONE && waited != 0) begin
        report_mismatch($sformatf("reply without slave took %0d extra cycles", waited));
      end
      @(posedge clk);
      #1;
      m_cyc_i  = 1'b0;
      m_stb_i  = 1'b0;
      m_we_i   = 1'b0;
      m_inta_i = 1'b0;
      if (r.op != OP_WR) check_data(rdat, r.rdat, "m_dat_o");
      if (r.op == OP_INTA) begin
        exp_line = lowest_line(pend_model);
        check_iid(rdat[2:0], exp_line);
        pend_model[exp_line] = 1'b0;
      end
      check_intr(m_intr_o, r.intr, "after bus cycle");
    end
  endtask

  initial begin
    void'($urandom(32'h9d67));
    rst        = 1'b1;
    m_adr_i    = '0;
    m_dat_i    = '0;
    m_sel_i    = '0;
    m_we_i     = 1'b0;
    m_cyc_i    = 1'b0;
    m_stb_i    = 1'b0;
    m_inta_i   = 1'b0;
    irq_i      = '0;
    ack_delay  = 0;
    pend_model = '0;
    build_table();
    cycle_limit = rows.size() * 8 + RST_CYCLES + 50;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    check_intr(m_intr_o, 1'b0, "after reset");
    foreach (rows[i]) begin
      @(posedge clk);
      #1;
      run_row(rows[i]);
    end
    $display("Done: no errors");
    $finish;
  end

endmodule

//--- kotku_bus.f
+incdir+src
src/kotku_pkg.sv
src/wb_slave_switch.sv
src/simple_pic.sv
src/cpu_bus_port.sv
src/kotku_bus.sv
tb/kotku_bus_sva.sv
tb/tb_kotku_bus.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_kotku_bus
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= kotku_bus.f

.PHONY: compile run clean

compile:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the log decides pass or fail, not the exit status of the binary
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Done: no errors" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
